/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

  // Data path and register file geometry
  localparam int XLEN = 64;
  localparam int REG_IDX_W = 5;
  localparam int INSTR_W = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [INSTR_W-1:0] instr_t;

  // ALU operation select
  typedef logic [1:0] alu_op_t;

  localparam alu_op_t ALU_AND = 2'b00;
  localparam alu_op_t ALU_ORR = 2'b01;
  localparam alu_op_t ALU_ADD = 2'b10;
  localparam alu_op_t ALU_SUB = 2'b11;

  // Opcode field, instruction bits 31..21
  localparam logic [10:0] OPC_ADD = 11'b10001011000;
  localparam logic [10:0] OPC_SUB = 11'b11001011000;
  localparam logic [10:0] OPC_AND = 11'b10001010000;
  localparam logic [10:0] OPC_ORR = 11'b10101010000;

  // x31 reads as zero and is never written
  localparam reg_idx_t ZERO_REG = 5'd31;

  // One issue slot as seen by a lane
  typedef struct packed {
    logic valid;
    instr_t instr;
  } issue_t;

  // Write-back record, also the bypass source for both lanes
  typedef struct packed {
    logic valid;
    reg_idx_t rd;
    xlen_t data;
  } wb_t;

endpackage

`default_nettype wire

/* lane/exec_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_lane (
  input  logic               CLOCK,
  input  logic               reset,
  input  core_pkg::issue_t   issue,
  output core_pkg::reg_idx_t rd_idx_a,
  output core_pkg::reg_idx_t rd_idx_b,
  input  core_pkg::xlen_t    rd_data_a,
  input  core_pkg::xlen_t    rd_data_b,
  input  core_pkg::wb_t      bypass0,
  input  core_pkg::wb_t      bypass1,
  output core_pkg::wb_t      wb
);

  import core_pkg::*;

  alu_op_t  alu_op;
  reg_idx_t rn;
  reg_idx_t rm;
  reg_idx_t rd;
  logic     writes;

  xlen_t op_a;
  xlen_t op_b;
  xlen_t alu_result;

  instr_decode u_instr_decode (
    .instr  (issue.instr),
    .alu_op (alu_op),
    .rn     (rn),
    .rm     (rm),
    .rd     (rd),
    .writes (writes)
  );

  // Sources go straight to the register file read ports
  assign rd_idx_a = rn;
  assign rd_idx_b = rm;

  // Pick the newest value of a source register
  // Lane 1 record is younger, so it is checked before lane 0
  function automatic xlen_t select_operand(
    input reg_idx_t idx,
    input xlen_t    rf_val,
    input wb_t      byp0,
    input wb_t      byp1
  );
    xlen_t val;
    if (idx == ZERO_REG) begin
      val = '0;
    end else if (byp1.valid && (byp1.rd == idx)) begin
      val = byp1.data;
    end else if (byp0.valid && (byp0.rd == idx)) begin
      val = byp0.data;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  assign op_a = select_operand(rn, rd_data_a, bypass0, bypass1);
  assign op_b = select_operand(rm, rd_data_b, bypass0, bypass1);

  always_comb begin
    case (alu_op)
      ALU_AND: alu_result = op_a & op_b;
      ALU_ORR: alu_result = op_a | op_b;
      ALU_ADD: alu_result = op_a + op_b;
      ALU_SUB: alu_result = op_a - op_b;  // Wraps modulo 2^64
    endcase
  end

  // Write-back record, one cycle after issue
  always_ff @(posedge CLOCK) begin
    wb.rd   <= rd;
    wb.data <= alu_result;
    if (reset) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= issue.valid && writes;
    end
  end

endmodule

`default_nettype wire

/* lane/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  core_pkg::instr_t   instr,
  output core_pkg::alu_op_t  alu_op,
  output core_pkg::reg_idx_t rn,
  output core_pkg::reg_idx_t rm,
  output core_pkg::reg_idx_t rd,
  output logic               writes
);

  import core_pkg::*;

  logic known_op;  // One of the four R-type opcodes

  // R-type register fields
  assign rn = instr[9:5];
  assign rm = instr[20:16];
  assign rd = instr[4:0];

  always_comb begin
    alu_op   = ALU_AND;
    known_op = 1'b1;
    case (instr[31:21])
      OPC_ADD: alu_op = ALU_ADD;
      OPC_SUB: alu_op = ALU_SUB;
      OPC_AND: alu_op = ALU_AND;
      OPC_ORR: alu_op = ALU_ORR;
      default: known_op = 1'b0;  // Anything else behaves as a NOP
    endcase
  end

  // A write to x31 is dropped here, so no record ever carries rd 31
  assign writes = known_op && (rd != ZERO_REG);

endmodule

`default_nettype wire

/* rtl/dual_issue_core.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core (
  input  logic             CLOCK,
  input  logic             reset,
  input  core_pkg::issue_t issue0,
  input  core_pkg::issue_t issue1,
  output core_pkg::wb_t    result0,
  output core_pkg::wb_t    result1
);

  import core_pkg::*;

  // Register file read indices and data, per lane
  reg_idx_t raddr0a;
  reg_idx_t raddr0b;
  reg_idx_t raddr1a;
  reg_idx_t raddr1b;
  xlen_t    rdata0a;
  xlen_t    rdata0b;
  xlen_t    rdata1a;
  xlen_t    rdata1b;

  wb_t wb0;  // Older lane
  wb_t wb1;  // Younger lane

  exec_lane u_lane0 (
    .CLOCK     (CLOCK),
    .reset     (reset),
    .issue     (issue0),
    .rd_idx_a  (raddr0a),
    .rd_idx_b  (raddr0b),
    .rd_data_a (rdata0a),
    .rd_data_b (rdata0b),
    .bypass0   (wb0),
    .bypass1   (wb1),
    .wb        (wb0)
  );

  exec_lane u_lane1 (
    .CLOCK     (CLOCK),
    .reset     (reset),
    .issue     (issue1),
    .rd_idx_a  (raddr1a),
    .rd_idx_b  (raddr1b),
    .rd_data_a (rdata1a),
    .rd_data_b (rdata1b),
    .bypass0   (wb0),
    .bypass1   (wb1),
    .wb        (wb1)
  );

  register_file u_register_file (
    .CLOCK   (CLOCK),
    .reset   (reset),
    .raddr0a (raddr0a),
    .raddr0b (raddr0b),
    .raddr1a (raddr1a),
    .raddr1b (raddr1b),
    .rdata0a (rdata0a),
    .rdata0b (rdata0b),
    .rdata1a (rdata1a),
    .rdata1b (rdata1b),
    .wb0     (wb0),
    .wb1     (wb1)
  );

  // Records leave the core in the same cycle they feed the file
  assign result0 = wb0;
  assign result1 = wb1;

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic               CLOCK,
  input  logic               reset,
  input  core_pkg::reg_idx_t raddr0a,
  input  core_pkg::reg_idx_t raddr0b,
  input  core_pkg::reg_idx_t raddr1a,
  input  core_pkg::reg_idx_t raddr1b,
  output core_pkg::xlen_t    rdata0a,
  output core_pkg::xlen_t    rdata0b,
  output core_pkg::xlen_t    rdata1a,
  output core_pkg::xlen_t    rdata1b,
  input  core_pkg::wb_t      wb0,
  input  core_pkg::wb_t      wb1
);

  import core_pkg::*;

  xlen_t regs [NUM_REGS];

  // The read mux returns zero for x31
  function automatic xlen_t read_reg(input reg_idx_t idx);
    xlen_t val;
    if (idx == ZERO_REG) begin
      val = '0;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  // Combinational read ports, two per lane
  assign rdata0a = read_reg(raddr0a);
  assign rdata0b = read_reg(raddr0b);
  assign rdata1a = read_reg(raddr1a);
  assign rdata1b = read_reg(raddr1b);

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      // Register i starts out holding i
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= (i == int'(ZERO_REG)) ? '0 : xlen_t'(i);
      end
    end else begin
      if (wb0.valid && (wb0.rd != ZERO_REG)) begin
        regs[wb0.rd] <= wb0.data;
      end
      // Lane 1 is younger; its write lands last on a clash
      if (wb1.valid && (wb1.rd != ZERO_REG)) begin
        regs[wb1.rd] <= wb1.data;
      end
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the dual-issue core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dual_issue_core -Mdir "$BUILD_DIR" -o sim_tb -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi
exit 0

/* sources.f */
common/core_pkg.sv
lane/instr_decode.sv
lane/exec_lane.sv
rtl/register_file.sv
rtl/dual_issue_core.sv
test/core_assert.sv
test/tb_dual_issue_core.sv

/* test/core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module core_assert (
  input logic             CLOCK,
  input logic             reset,
  input core_pkg::issue_t issue0,
  input core_pkg::issue_t issue1,
  input core_pkg::wb_t    result0,
  input core_pkg::wb_t    result1
);

  import core_pkg::*;

  // Both records are cleared by reset
  a_reset_clears: assert property (@(posedge CLOCK)
    reset |=> (!result0.valid && !result1.valid))
    else $error("Result valid high in the cycle after reset");

  a_no_x31_0: assert property (@(posedge CLOCK) disable iff (reset)
    result0.valid |-> (result0.rd != ZERO_REG))
    else $error("Lane 0 result targets x31");

  a_no_x31_1: assert property (@(posedge CLOCK) disable iff (reset)
    result1.valid |-> (result1.rd != ZERO_REG))
    else $error("Lane 1 result targets x31");

  // One-cycle latency from issue to result
  a_issue_0: assert property (@(posedge CLOCK) disable iff (reset)
    result0.valid |-> $past(issue0.valid))
    else $error("Lane 0 result without an issue");

  a_issue_1: assert property (@(posedge CLOCK) disable iff (reset)
    result1.valid |-> $past(issue1.valid))
    else $error("Lane 1 result without an issue");

endmodule

bind dual_issue_core core_assert u_core_assert (
  .CLOCK   (CLOCK),
  .reset   (reset),
  .issue0  (issue0),
  .issue1  (issue1),
  .result0 (result0),
  .result1 (result1)
);

`default_nettype wire

/* test/tb_dual_issue_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue_core;

  import core_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_VECTORS = 12;
  localparam int NUM_RANDOM = 200;
  localparam int TIMEOUT_CYCLES = NUM_VECTORS + NUM_RANDOM + 20;

  // One hand-written pair and its expected records
  typedef struct packed {
    issue_t i0;
    issue_t i1;
    wb_t    e0;
    wb_t    e1;
  } vec_t;

  logic   CLOCK;
  logic   reset;
  issue_t issue0;
  issue_t issue1;
  wb_t    result0;
  wb_t    result1;

  vec_t        vectors [NUM_VECTORS];
  int          vec_count;
  xlen_t       ref_regs [NUM_REGS];  // Architectural state of the model
  logic [31:0] lcg_state;

  dual_issue_core u_dual_issue_core (
    .CLOCK   (CLOCK),
    .reset   (reset),
    .issue0  (issue0),
    .issue1  (issue1),
    .result0 (result0),
    .result1 (result1)
  );

  initial begin
    CLOCK = 1'b0;
    forever #(CLK_PERIOD / 2) CLOCK = ~CLOCK;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Run aborted");
  endtask

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    abort_run("Timeout: the test sequence did not finish in time");
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic instr_t encode_rtype(input logic [10:0] opc, input reg_idx_t rd,
                                          input reg_idx_t rn, input reg_idx_t rm);
    return {opc, rm, 6'd0, rn, rd};  // shamt stays zero
  endfunction

  function automatic issue_t make_issue(input logic valid, input instr_t instr);
    issue_t is;
    is.valid = valid;
    is.instr = instr;
    return is;
  endfunction

  function automatic wb_t make_wb(input logic valid, input reg_idx_t rd, input xlen_t data);
    wb_t r;
    r.valid = valid;
    r.rd    = rd;
    r.data  = data;
    return r;
  endfunction

  // rd and data only matter for a valid record
  function automatic bit wb_match(input wb_t act, input wb_t exp);
    if (act.valid !== exp.valid) return 1'b0;
    if (exp.valid && ((act.rd !== exp.rd) || (act.data !== exp.data))) return 1'b0;
    return 1'b1;
  endfunction

  task automatic check_wb(input string port, input wb_t act, input wb_t exp);
    if (!wb_match(act, exp)) begin
      abort_run($sformatf(
          "ERR %0t %s: got valid=%0b rd=%0d data=%h, expected valid=%0b rd=%0d data=%h",
          $time, port, act.valid, act.rd, act.data,
          exp.valid, exp.rd, exp.data));
    end
  endtask

  // Executes one instruction against the model state
  function automatic wb_t model_exec(input issue_t is);
    logic [10:0] opc;
    xlen_t       a;
    xlen_t       b;
    wb_t         r;
    logic        known;
    opc    = is.instr[31:21];
    a      = ref_regs[is.instr[9:5]];
    b      = ref_regs[is.instr[20:16]];
    r      = '0;
    r.rd   = is.instr[4:0];
    known  = 1'b1;
    case (opc)
      OPC_ADD: r.data = a + b;
      OPC_SUB: r.data = a - b;
      OPC_AND: r.data = a & b;
      OPC_ORR: r.data = a | b;
      default: known = 1'b0;
    endcase
    r.valid = is.valid && known && (r.rd != ZERO_REG);
    return r;
  endfunction

  // Both lanes read the old state, then commit in program order
  task automatic model_pair(input issue_t i0, input issue_t i1, output wb_t e0, output wb_t e1);
    e0 = model_exec(i0);
    e1 = model_exec(i1);
    if (e0.valid) ref_regs[e0.rd] = e0.data;
    if (e1.valid) ref_regs[e1.rd] = e1.data;
  endtask

  task automatic add_vector(input issue_t i0, input issue_t i1, input wb_t e0, input wb_t e1);
    vectors[vec_count] = {i0, i1, e0, e1};
    vec_count++;
  endtask

  task automatic load_table();
    vec_count = 0;
    add_vector(make_issue(1'b1, encode_rtype(OPC_ADD, 5'd1, 5'd2, 5'd3)),
               make_issue(1'b1, encode_rtype(OPC_ORR, 5'd4, 5'd5, 5'd6)),
               make_wb(1'b1, 5'd1, 64'd5), make_wb(1'b1, 5'd4, 64'd7));
    add_vector(make_issue(1'b1, encode_rtype(OPC_AND, 5'd7, 5'd12, 5'd10)),
               make_issue(1'b1, encode_rtype(OPC_SUB, 5'd8, 5'd9, 5'd2)),
               make_wb(1'b1, 5'd7, 64'd8), make_wb(1'b1, 5'd8, 64'd7));
    // Bypass from both lanes, SUB below zero
    add_vector(make_issue(1'b1, encode_rtype(OPC_ADD, 5'd9, 5'd7, 5'd8)),
               make_issue(1'b1, encode_rtype(OPC_SUB, 5'd10, 5'd3, 5'd7)),
               make_wb(1'b1, 5'd9, 64'd15), make_wb(1'b1, 5'd10, 64'hFFFF_FFFF_FFFF_FFFB));
    add_vector(make_issue(1'b1, encode_rtype(OPC_SUB, 5'd11, 5'd9, 5'd10)),
               make_issue(1'b1, encode_rtype(OPC_ORR, 5'd12, 5'd10, 5'd31)),
               make_wb(1'b1, 5'd11, 64'd20), make_wb(1'b1, 5'd12, 64'hFFFF_FFFF_FFFF_FFFB));
    add_vector(make_issue(1'b1, encode_rtype(OPC_ADD, 5'd13, 5'd11, 5'd11)),
               make_issue(1'b1, encode_rtype(OPC_AND, 5'd13, 5'd12, 5'd9)),
               make_wb(1'b1, 5'd13, 64'd40), make_wb(1'b1, 5'd13, 64'd11));
    add_vector(make_issue(1'b1, encode_rtype(OPC_ADD, 5'd14, 5'd13, 5'd1)),   // Lane 1 wins
               make_issue(1'b1, encode_rtype(OPC_ORR, 5'd15, 5'd13, 5'd0)),
               make_wb(1'b1, 5'd14, 64'd16), make_wb(1'b1, 5'd15, 64'd11));
    add_vector(make_issue(1'b1, encode_rtype(OPC_SUB, 5'd16, 5'd13, 5'd2)),
               make_issue(1'b1, encode_rtype(OPC_ADD, 5'd17, 5'd31, 5'd31)),
               make_wb(1'b1, 5'd16, 64'd9), make_wb(1'b1, 5'd17, 64'd0));
    add_vector(make_issue(1'b1, encode_rtype(OPC_ADD, 5'd31, 5'd1, 5'd2)),    // Write to x31
               make_issue(1'b1, encode_rtype(OPC_ORR, 5'd18, 5'd31, 5'd16)),
               make_wb(1'b0, 5'd0, 64'd0), make_wb(1'b1, 5'd18, 64'd9));
    add_vector(make_issue(1'b1, encode_rtype(11'h7FF, 5'd19, 5'd1, 5'd2)),    // Unknown opcode
               make_issue(1'b1, encode_rtype(OPC_ADD, 5'd20, 5'd19, 5'd18)),
               make_wb(1'b0, 5'd0, 64'd0), make_wb(1'b1, 5'd20, 64'd28));
    add_vector(make_issue(1'b0, encode_rtype(OPC_ADD, 5'd21, 5'd1, 5'd1)),
               make_issue(1'b0, encode_rtype(OPC_ADD, 5'd22, 5'd2, 5'd2)),
               make_wb(1'b0, 5'd0, 64'd0), make_wb(1'b0, 5'd0, 64'd0));
    add_vector(make_issue(1'b1, encode_rtype(OPC_ADD, 5'd23, 5'd21, 5'd22)),
               make_issue(1'b1, encode_rtype(OPC_SUB, 5'd24, 5'd22, 5'd21)),
               make_wb(1'b1, 5'd23, 64'd43), make_wb(1'b1, 5'd24, 64'd1));
    add_vector(make_issue(1'b1, encode_rtype(OPC_ORR, 5'd25, 5'd31, 5'd20)),
               make_issue(1'b1, encode_rtype(OPC_AND, 5'd26, 5'd31, 5'd24)),
               make_wb(1'b1, 5'd25, 64'd28), make_wb(1'b1, 5'd26, 64'd0));
  endtask

  function automatic issue_t random_issue();
    logic [31:0] r;
    logic [10:0] opc;
    r = next_rand();
    case (r[31:29])
      3'd0, 3'd1: opc = OPC_ADD;
      3'd2, 3'd5: opc = OPC_SUB;
      3'd3:       opc = OPC_AND;
      3'd4, 3'd6: opc = OPC_ORR;
      default:    opc = 11'h7FF;  // NOP now and then
    endcase
    return make_issue(r[28:26] != 3'd0, encode_rtype(opc, r[20:16], r[15:11], r[10:6]));
  endfunction

  // Lane 1 sources never name lane 0's destination
  task automatic make_random_pair(output issue_t i0, output issue_t i1);
    logic [31:0] r;
    i0 = random_issue();
    i1 = random_issue();
    while (i1.instr[9:5] == i0.instr[4:0]) begin
      r = next_rand();
      i1.instr[9:5] = r[24:20];
    end
    while (i1.instr[20:16] == i0.instr[4:0]) begin
      r = next_rand();
      i1.instr[20:16] = r[24:20];
    end
  endtask

  // Drive at a falling edge, check one cycle later
  task automatic apply_pair(input issue_t i0, input issue_t i1, input wb_t e0, input wb_t e1);
    issue0 = i0;
    issue1 = i1;
    @(negedge CLOCK);
    check_wb("result0", result0, e0);
    check_wb("result1", result1, e1);
  endtask

  initial begin
    issue_t ri0;
    issue_t ri1;
    wb_t    m0;
    wb_t    m1;
    reset     = 1'b1;
    // Valid pairs during reset, which must discard them
    issue0    = make_issue(1'b1, encode_rtype(OPC_ADD, 5'd1, 5'd2, 5'd3));
    issue1    = make_issue(1'b1, encode_rtype(OPC_ORR, 5'd4, 5'd5, 5'd6));
    lcg_state = 32'd15;
    for (int i = 0; i < NUM_REGS; i++) begin
      ref_regs[i] = (i == int'(ZERO_REG)) ? '0 : xlen_t'(i);
    end
    load_table();
    repeat (5) @(posedge CLOCK);
    @(negedge CLOCK);
    reset = 1'b0;
    check_wb("result0", result0, '0);
    check_wb("result1", result1, '0);

    for (int n = 0; n < NUM_VECTORS; n++) begin
      model_pair(vectors[n].i0, vectors[n].i1, m0, m1);
      if (!wb_match(m0, vectors[n].e0) || !wb_match(m1, vectors[n].e1)) begin
        abort_run($sformatf("Table entry %0d disagrees with the reference model", n));
      end
      apply_pair(vectors[n].i0, vectors[n].i1, vectors[n].e0, vectors[n].e1);
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      make_random_pair(ri0, ri1);
      model_pair(ri0, ri1, m0, m1);
      apply_pair(ri0, ri1, m0, m1);
    end

    apply_pair('0, '0, '0, '0);  // Drain with an idle pair
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
